// ==== src/exec_pkg.sv ====
package exec_pkg;

    localparam int DATA_W = 32;

    typedef enum logic [1:0] {
        CLS_ALU    = 2'd0,
        CLS_MEM    = 2'd1,
        CLS_BRANCH = 2'd2,
        CLS_JUMP   = 2'd3
    } instr_class_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        AGU_BYTE = 3'd0,
        AGU_HALF = 3'd1,
        AGU_WORD = 3'd2,
        AGU_JTGT = 3'd3
    } agu_op_e;

    typedef enum logic [1:0] {
        SEL_REG       = 2'd0,
        SEL_PREV_ALU  = 2'd1,
        SEL_PREV_ADDR = 2'd2,
        SEL_ZERO      = 2'd3
    } op_sel_e;

    typedef struct packed {
        instr_class_e cls;
        alu_op_e      alu_op;
        op_sel_e      sel_a;
        op_sel_e      sel_b;
        logic [21:0]  pad;
    } r_form_s;

    // class bits line up with r_form.
    typedef struct packed {
        instr_class_e cls;
        agu_op_e      agu_op;
        logic [25:0]  offset;
        logic         pad;
    } m_form_s;

    typedef union packed {
        r_form_s r_form;
        m_form_s m_form;
    } exec_instr_u;

    typedef struct packed {
        logic              issue;
        logic [DATA_W-1:0] src_a;
        logic [DATA_W-1:0] src_b;
        exec_instr_u       instr;
    } lane_cmd_s;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] alu_rslt;
        logic [DATA_W-1:0] eff_addr;
        logic              pc_take;
        logic              addr_err;
    } lane_rslt_s;

endpackage

// ==== src/apb_pkg.sv ====
package apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_s;

    // offsets inside one 16-byte lane window.
    localparam logic [3:0] REG_SRC_A  = 4'h0;
    localparam logic [3:0] REG_ALU    = 4'h0;
    localparam logic [3:0] REG_SRC_B  = 4'h4;
    localparam logic [3:0] REG_ADDR   = 4'h4;
    localparam logic [3:0] REG_INSTR  = 4'h8;
    localparam logic [3:0] REG_STATUS = 4'hC;

endpackage

// ==== src/exec_alu.sv ====
`timescale 1ns/1ps

module exec_alu
    import exec_pkg::*;
(
    input  alu_op_e           i_op,
    input  logic [DATA_W-1:0] i_a,
    input  logic [DATA_W-1:0] i_b,
    output logic [DATA_W-1:0] o_rslt
);

    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    always_comb begin
        case (i_op)
            ALU_ADD: begin
                o_rslt = i_a + i_b;
            end
            ALU_SUB: begin
                o_rslt = i_a - i_b;
            end
            ALU_AND: begin
                o_rslt = i_a & i_b;
            end
            ALU_OR: begin
                o_rslt = i_a | i_b;
            end
            ALU_XOR: begin
                o_rslt = i_a ^ i_b;
            end
            ALU_NOR: begin
                o_rslt = ~(i_a | i_b);
            end
            ALU_SLT: begin
                o_rslt = {{(DATA_W-1){1'b0}}, ($signed(i_a) < $signed(i_b))};
            end
            ALU_SLTU: begin
                o_rslt = {{(DATA_W-1){1'b0}}, (i_a < i_b)};
            end
            ALU_SLL: begin
                o_rslt = i_a << shamt;
            end
            ALU_SRL: begin
                o_rslt = i_a >> shamt;
            end
            // unused opcodes.
            default: begin
                o_rslt = '0;
            end
        endcase
    end

endmodule

// ==== src/exec_lane.sv ====
`timescale 1ns/1ps

module exec_lane
    import exec_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  lane_cmd_s  i_cmd,
    output lane_rslt_s o_rslt
);

    instr_class_e      cls;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_out;
    logic [DATA_W-1:0] addr_sum;
    logic [DATA_W-1:0] eff_addr;
    logic              addr_err;
    logic              pc_take;
    logic [DATA_W-1:0] prev_alu_q;
    logic [DATA_W-1:0] prev_addr_q;
    logic              valid_q;
    logic              pc_take_q;
    logic              addr_err_q;

    function automatic logic [DATA_W-1:0] pick(input op_sel_e sel,
                                               input logic [DATA_W-1:0] reg_val,
                                               input logic [DATA_W-1:0] prev_alu,
                                               input logic [DATA_W-1:0] prev_addr);
        case (sel)
            SEL_REG:       return reg_val;
            SEL_PREV_ALU:  return prev_alu;
            SEL_PREV_ADDR: return prev_addr;
            default:       return '0;
        endcase
    endfunction

    assign cls = i_cmd.instr.r_form.cls;

    // mem also takes its base through sel_a.
    assign op_a = pick(i_cmd.instr.r_form.sel_a, i_cmd.src_a, prev_alu_q, prev_addr_q);
    assign op_b = pick(i_cmd.instr.r_form.sel_b, i_cmd.src_b, prev_alu_q, prev_addr_q);

    exec_alu u_alu (
        .i_op   (i_cmd.instr.r_form.alu_op),
        .i_a    (op_a),
        .i_b    (op_b),
        .o_rslt (alu_out)
    );

    assign addr_sum = op_a + {{16{i_cmd.instr.m_form.offset[15]}}, i_cmd.instr.m_form.offset[15:0]};

    always_comb begin
        eff_addr = addr_sum;
        addr_err = 1'b0;
        case (i_cmd.instr.m_form.agu_op)
            AGU_HALF: addr_err = addr_sum[0];
            AGU_WORD: addr_err = |addr_sum[1:0];
            AGU_JTGT: eff_addr = {op_a[31:28], i_cmd.instr.m_form.offset, 2'b00};
            default:  ;
        endcase
    end

    // branch decides on the lowest result bit.
    assign pc_take = (cls == CLS_JUMP) || ((cls == CLS_BRANCH) && alu_out[0]);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q     <= 1'b0;
            pc_take_q   <= 1'b0;
            addr_err_q  <= 1'b0;
            prev_alu_q  <= '0;
            prev_addr_q <= '0;
        end else begin
            valid_q <= i_cmd.issue;
            if (i_cmd.issue) begin
                pc_take_q <= pc_take;
                if (cls == CLS_MEM) begin
                    prev_alu_q  <= '0;
                    prev_addr_q <= eff_addr;
                    addr_err_q  <= addr_err;
                end else begin
                    prev_alu_q <= alu_out;
                    addr_err_q <= 1'b0;
                end
            end
        end
    end

    assign o_rslt = '{valid: valid_q, alu_rslt: prev_alu_q, eff_addr: prev_addr_q,
                      pc_take: pc_take_q, addr_err: addr_err_q};

endmodule

// ==== src/exec_dispatch.sv ====
`timescale 1ns/1ps

module exec_dispatch
    import exec_pkg::*;
    import apb_pkg::*;
#(
    parameter int N_LANES = 4
) (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  apb_req_s                i_apb,
    output logic [DATA_W-1:0]       o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,
    output lane_cmd_s [N_LANES-1:0] o_cmd,
    output logic [3:0]              o_rd_lane,
    input  logic [DATA_W-1:0]       i_rd_alu,
    input  logic [DATA_W-1:0]       i_rd_addr,
    input  logic [DATA_W-1:0]       i_rd_status,
    output logic [N_LANES-1:0]      o_status_clr
);

    logic [3:0] lane;
    logic [3:0] offset;
    logic       lane_ok;
    logic       access;
    logic       wr_en;
    logic       rd_en;

    assign lane    = i_apb.paddr[7:4];
    assign offset  = i_apb.paddr[3:0];
    assign lane_ok = (int'(lane) < N_LANES);
    assign access  = i_apb.psel & i_apb.penable;
    assign wr_en   = access & i_apb.pwrite & lane_ok;
    assign rd_en   = access & ~i_apb.pwrite & lane_ok;

    // no wait states.
    assign o_pready  = 1'b1;
    assign o_pslverr = access & ~lane_ok;
    assign o_rd_lane = lane;

    // collector already selected the lane.
    always_comb begin
        o_prdata = '0;
        if (rd_en) begin
            case (offset)
                REG_ALU:    o_prdata = i_rd_alu;
                REG_ADDR:   o_prdata = i_rd_addr;
                REG_STATUS: o_prdata = i_rd_status;
                default:    o_prdata = '0;
            endcase
        end
    end

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        logic              hit;
        logic [DATA_W-1:0] src_a_q;
        logic [DATA_W-1:0] src_b_q;
        exec_instr_u       instr_q;
        logic              issue_q;

        assign hit = (lane == 4'(i));

        always_ff @(posedge i_clk) begin
            if (wr_en && hit) begin
                case (offset)
                    REG_SRC_A: src_a_q <= i_apb.pwdata;
                    REG_SRC_B: src_b_q <= i_apb.pwdata;
                    REG_INSTR: instr_q <= i_apb.pwdata;
                    default:   ;
                endcase
            end
        end

        // one-cycle pulse after the instruction write.
        always_ff @(posedge i_clk or negedge i_arst_n) begin
            if (!i_arst_n) begin
                issue_q <= 1'b0;
            end else begin
                issue_q <= wr_en && hit && (offset == REG_INSTR);
            end
        end

        assign o_status_clr[i] = rd_en && hit && (offset == REG_STATUS);
        assign o_cmd[i] = '{issue: issue_q, src_a: src_a_q, src_b: src_b_q, instr: instr_q};
    end

endmodule

// ==== src/exec_collect.sv ====
`timescale 1ns/1ps

module exec_collect
    import exec_pkg::*;
#(
    parameter int N_LANES = 4
) (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  lane_rslt_s [N_LANES-1:0] i_rslt,
    input  logic [3:0]               i_rd_lane,
    input  logic [N_LANES-1:0]       i_status_clr,
    output logic [DATA_W-1:0]        o_rd_alu,
    output logic [DATA_W-1:0]        o_rd_addr,
    output logic [DATA_W-1:0]        o_rd_status
);

    logic [DATA_W-1:0]  alu_q [N_LANES];
    logic [DATA_W-1:0]  addr_q [N_LANES];
    logic [N_LANES-1:0] valid_q;
    logic [N_LANES-1:0] pc_take_q;
    logic [N_LANES-1:0] addr_err_q;

    for (genvar i = 0; i < N_LANES; i++) begin : g_store
        always_ff @(posedge i_clk) begin
            if (i_rslt[i].valid) begin
                alu_q[i]  <= i_rslt[i].alu_rslt;
                addr_q[i] <= i_rslt[i].eff_addr;
            end
        end

        // a new result wins over a clear in the same cycle.
        always_ff @(posedge i_clk or negedge i_arst_n) begin
            if (!i_arst_n) begin
                valid_q[i]    <= 1'b0;
                pc_take_q[i]  <= 1'b0;
                addr_err_q[i] <= 1'b0;
            end else if (i_rslt[i].valid) begin
                valid_q[i]    <= 1'b1;
                pc_take_q[i]  <= i_rslt[i].pc_take;
                addr_err_q[i] <= i_rslt[i].addr_err;
            end else if (i_status_clr[i]) begin
                valid_q[i] <= 1'b0;
            end
        end
    end

    // lanes past N_LANES read as zero.
    always_comb begin
        o_rd_alu    = '0;
        o_rd_addr   = '0;
        o_rd_status = '0;
        for (int i = 0; i < N_LANES; i++) begin
            if (i_rd_lane == 4'(i)) begin
                o_rd_alu    = alu_q[i];
                o_rd_addr   = addr_q[i];
                o_rd_status = {{(DATA_W-3){1'b0}}, addr_err_q[i], pc_take_q[i], valid_q[i]};
            end
        end
    end

endmodule

// ==== src/exec_cluster.sv ====
`timescale 1ns/1ps

module exec_cluster
    import exec_pkg::*;
    import apb_pkg::*;
#(
    parameter int N_LANES = 4
) (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  apb_req_s          i_apb,
    output logic [DATA_W-1:0] o_prdata,
    output logic              o_pready,
    output logic              o_pslverr
);

    lane_cmd_s  [N_LANES-1:0] lane_cmd;
    lane_rslt_s [N_LANES-1:0] lane_rslt;
    logic [3:0]               rd_lane;
    logic [DATA_W-1:0]        rd_alu;
    logic [DATA_W-1:0]        rd_addr;
    logic [DATA_W-1:0]        rd_status;
    logic [N_LANES-1:0]       status_clr;

    exec_dispatch #(.N_LANES(N_LANES)) u_dispatch (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_apb        (i_apb),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_cmd        (lane_cmd),
        .o_rd_lane    (rd_lane),
        .i_rd_alu     (rd_alu),
        .i_rd_addr    (rd_addr),
        .i_rd_status  (rd_status),
        .o_status_clr (status_clr)
    );

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        exec_lane u_lane (
            .i_clk    (i_clk),
            .i_arst_n (i_arst_n),
            .i_cmd    (lane_cmd[i]),
            .o_rslt   (lane_rslt[i])
        );
    end

    exec_collect #(.N_LANES(N_LANES)) u_collect (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_rslt       (lane_rslt),
        .i_rd_lane    (rd_lane),
        .i_status_clr (status_clr),
        .o_rd_alu     (rd_alu),
        .o_rd_addr    (rd_addr),
        .o_rd_status  (rd_status)
    );

endmodule

// ==== bench/exec_cluster_sva.sv ====
`timescale 1ns/1ps

module exec_cluster_sva
    import exec_pkg::*;
    import apb_pkg::*;
#(
    parameter int N_LANES = 4
) (
    input logic                     i_clk,
    input logic                     i_arst_n,
    input apb_req_s                 i_apb,
    input logic                     i_pready,
    input logic                     i_pslverr,
    input lane_cmd_s  [N_LANES-1:0] i_cmd,
    input lane_rslt_s [N_LANES-1:0] i_rslt
);

    int                 fail_cnt;
    logic               access;
    logic               bad_lane;
    logic [N_LANES-1:0] instr_wr;
    logic [N_LANES-1:0] issue_vec;
    logic [N_LANES-1:0] valid_vec;

    assign access   = i_apb.psel && i_apb.penable;
    assign bad_lane = (int'(i_apb.paddr[7:4]) >= N_LANES);

    for (genvar i = 0; i < N_LANES; i++) begin : g_vec
        assign instr_wr[i]  = access && i_apb.pwrite && (i_apb.paddr == {4'(i), REG_INSTR});
        assign issue_vec[i] = i_cmd[i].issue;
        assign valid_vec[i] = i_rslt[i].valid;
    end

    a_pready: assert property (@(posedge i_clk) disable iff (!i_arst_n) i_pready)
        else begin
            fail_cnt++;
            $error("PREADY went low");
        end

    // issue exactly one cycle after an instruction write.
    a_issue: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                              issue_vec == $past(instr_wr))
        else begin
            fail_cnt++;
            $error("issue does not follow the instruction write");
        end

    a_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                              valid_vec == $past(issue_vec))
        else begin
            fail_cnt++;
            $error("lane valid does not follow issue");
        end

    a_slverr: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                               i_pslverr == (access && bad_lane))
        else begin
            fail_cnt++;
            $error("PSLVERR does not match the lane index");
        end

endmodule

bind exec_cluster exec_cluster_sva #(.N_LANES(N_LANES)) u_sva (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_apb     (i_apb),
    .i_pready  (o_pready),
    .i_pslverr (o_pslverr),
    .i_cmd     (lane_cmd),
    .i_rslt    (lane_rslt)
);

// ==== bench/tb_exec_cluster.sv ====
`timescale 1ns/1ps

module tb_exec_cluster
    import exec_pkg::*;
    import apb_pkg::*;
();

    localparam int N_LANES = 4;
    localparam int TIMEOUT = 50;
    localparam logic [3:0] OFF_A      = 4'h0;
    localparam logic [3:0] OFF_B      = 4'h4;
    localparam logic [3:0] OFF_INSTR  = 4'h8;
    localparam logic [3:0] OFF_STATUS = 4'hC;

    logic        clk;
    logic        arst_n;
    apb_req_s    apb;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    int          errors;
    int          timeouts;
    integer      seed;
    logic [31:0] prev_alu [N_LANES];
    logic [31:0] prev_addr [N_LANES];
    logic [31:0] exp_status [N_LANES];

    exec_cluster #(.N_LANES(N_LANES)) UUT (
        .i_clk     (clk),
        .i_arst_n  (arst_n),
        .i_apb     (apb),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [7:0] reg_addr(input int lane, input logic [3:0] off);
        return {4'(lane), off};
    endfunction

    function automatic logic [31:0] make_r(input logic [1:0] cls, input logic [3:0] op,
                                           input logic [1:0] sa, input logic [1:0] sb);
        return {cls, op, sa, sb, 22'd0};
    endfunction

    // base select overlays offset bits 24:23.
    function automatic logic [31:0] make_m(input logic [2:0] agu, input logic [1:0] sel,
                                           input logic [23:0] low);
        return {CLS_MEM, agu, low[23], sel, low[22:0], 1'b0};
    endfunction

    function automatic logic [31:0] operand(input logic [1:0] sel, input int lane,
                                            input logic [31:0] reg_val);
        case (sel)
            2'd0:    return reg_val;
            2'd1:    return prev_alu[lane];
            2'd2:    return prev_addr[lane];
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] alu_expect(input logic [3:0] op, input logic [31:0] a,
                                               input logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            default:  return 32'd0;
        endcase
    endfunction

    task automatic model_issue(input int lane, input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] instr);
        logic [1:0]  cls;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] alu;
        logic [31:0] sum;
        logic [31:0] ea;
        logic        err;
        logic        take;
        cls  = instr[31:30];
        op_a = operand(instr[25:24], lane, a);
        op_b = operand(instr[23:22], lane, b);
        alu  = alu_expect(instr[29:26], op_a, op_b);
        sum  = op_a + {{16{instr[16]}}, instr[16:1]};
        ea   = sum;
        err  = 1'b0;
        case (instr[29:27])
            3'd1:    err = sum[0];
            3'd2:    err = (sum[1:0] != 2'b00);
            3'd3:    ea = {op_a[31:28], instr[26:1], 2'b00};
            default: ;
        endcase
        take = (cls == CLS_JUMP) || ((cls == CLS_BRANCH) && alu[0]);
        if (cls == CLS_MEM) begin
            prev_alu[lane]  = 32'd0;
            prev_addr[lane] = ea;
        end else begin
            prev_alu[lane] = alu;
            err = 1'b0;
        end
        exp_status[lane] = {29'd0, err, take, 1'b1};
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        int n;
        @(posedge clk);
        apb <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb.penable <= 1'b1;
        @(negedge clk);
        n = 0;
        while (!pready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            timeouts++;
            $display("APB access to %h timed out with PREADY low", addr);
        end
        rdata  = prdata;
        slverr = pslverr;
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b1, addr, wdata, rdata, slverr);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
        logic slverr;
        apb_access(1'b0, addr, 32'd0, rdata, slverr);
    endtask

    task automatic load(input int lane, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] instr);
        model_issue(lane, a, b, instr);
        apb_write(reg_addr(lane, OFF_A), a);
        apb_write(reg_addr(lane, OFF_B), b);
        apb_write(reg_addr(lane, OFF_INSTR), instr);
    endtask

    // poll status until valid, then read both result words.
    task automatic check_lane(input int lane, input string name);
        logic [31:0] st;
        logic [31:0] rd;
        int          n;
        st = 32'd0;
        n  = 0;
        while (!st[0] && n < TIMEOUT) begin
            apb_read(reg_addr(lane, OFF_STATUS), st);
            n++;
        end
        if (!st[0]) begin
            timeouts++;
            $display("lane %0d result never became valid in %s", lane, name);
        end
        check_val({name, " status"}, exp_status[lane], st);
        apb_read(reg_addr(lane, OFF_A), rd);
        check_val({name, " alu"}, prev_alu[lane], rd);
        apb_read(reg_addr(lane, OFF_B), rd);
        check_val({name, " addr"}, prev_addr[lane], rd);
    endtask

    task automatic exercise(input int lane, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] instr, input string name);
        load(lane, a, b, instr);
        check_lane(lane, name);
    endtask

    initial begin
        int          lane;
        logic [31:0] base;
        logic [31:0] off;
        logic [31:0] rd;
        logic        slverr;
        errors   = 0;
        timeouts = 0;
        seed     = 25496;
        arst_n   = 1'b0;
        apb      = '0;
        for (int i = 0; i < N_LANES; i++) begin
            prev_alu[i]   = 32'd0;
            prev_addr[i]  = 32'd0;
            exp_status[i] = 32'd0;
        end
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        for (int op = 0; op < 10; op++) begin
            lane = ($random(seed) & 32'h7fff_ffff) % N_LANES;
            exercise(lane, $random(seed), $random(seed),
                     make_r(CLS_ALU, 4'(op), SEL_REG, SEL_REG),
                     $sformatf("alu op %0d lane %0d", op, lane));
        end

        exercise(1, 32'd100, 32'd23, make_r(CLS_ALU, ALU_ADD, SEL_REG, SEL_REG), "fwd add");
        exercise(1, 32'd0, 32'd5, make_r(CLS_ALU, ALU_SUB, SEL_PREV_ALU, SEL_REG), "fwd prev alu");
        exercise(1, 32'd0, 32'd0, make_m(AGU_WORD, SEL_PREV_ALU, 24'h000010), "fwd mem base");
        exercise(1, 32'd9, 32'd9, make_r(CLS_ALU, ALU_ADD, SEL_PREV_ADDR, SEL_ZERO),
                 "fwd prev addr");
        exercise(1, 32'hffff_ffff, 32'd0, make_r(CLS_ALU, ALU_OR, SEL_ZERO, SEL_PREV_ALU),
                 "fwd zero");
        exercise(2, 32'd7, 32'd0, make_r(CLS_ALU, ALU_ADD, SEL_PREV_ALU, SEL_PREV_ADDR),
                 "fwd other lane");

        // low base bits walk all alignments.
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 4; j++) begin
                lane      = ($random(seed) & 32'h7fff_ffff) % N_LANES;
                base      = $random(seed);
                base[1:0] = 2'(j);
                off       = $random(seed);
                off[1:0]  = 2'b00;
                exercise(lane, base, $random(seed), make_m(3'(k), SEL_REG, off[23:0]),
                         $sformatf("agu op %0d case %0d", k, j));
            end
        end

        exercise(0, 32'hffff_fffb, 32'd3, make_r(CLS_BRANCH, ALU_SLT, SEL_REG, SEL_REG),
                 "branch taken");
        exercise(0, 32'd7, 32'd2, make_r(CLS_BRANCH, ALU_SLT, SEL_REG, SEL_REG),
                 "branch not taken");
        exercise(3, $random(seed), $random(seed), make_r(CLS_JUMP, ALU_XOR, SEL_REG, SEL_REG),
                 "jump");
        exercise(3, 32'd1, 32'd2, make_r(CLS_ALU, ALU_SLT, SEL_REG, SEL_REG), "alu no take");
        exercise(3, $random(seed), 32'd0, make_m(AGU_BYTE, SEL_REG, 24'h000001), "mem no take");

        exercise(2, 32'd40, 32'd2, make_r(CLS_ALU, ALU_SRL, SEL_REG, SEL_REG), "status first");
        apb_read(reg_addr(2, OFF_STATUS), rd);
        check_val("status second read", exp_status[2] & ~32'd1, rd);

        for (int i = 0; i < N_LANES; i++) begin
            load(i, $random(seed), $random(seed), make_r(CLS_ALU, ALU_ADD, SEL_REG, SEL_PREV_ALU));
        end
        for (int i = 0; i < N_LANES; i++) begin
            check_lane(i, $sformatf("all lanes lane %0d", i));
        end

        apb_access(1'b1, reg_addr(5, OFF_A), $random(seed), rd, slverr);
        check_val("lane 5 write pslverr", 32'd1, {31'd0, slverr});
        apb_access(1'b1, reg_addr(5, OFF_INSTR), make_r(CLS_JUMP, ALU_ADD, SEL_REG, SEL_REG),
                   rd, slverr);
        check_val("lane 5 instr pslverr", 32'd1, {31'd0, slverr});
        apb_access(1'b0, reg_addr(5, OFF_A), 32'd0, rd, slverr);
        check_val("lane 5 read pslverr", 32'd1, {31'd0, slverr});
        check_val("lane 5 read data", 32'd0, rd);
        for (int i = 0; i < N_LANES; i++) begin
            apb_read(reg_addr(i, OFF_A), rd);
            check_val($sformatf("lane %0d alu kept", i), prev_alu[i], rd);
            apb_read(reg_addr(i, OFF_B), rd);
            check_val($sformatf("lane %0d addr kept", i), prev_addr[i], rd);
        end

        repeat (4) @(posedge clk);
        $display("check errors: %0d, timeouts: %0d, assertion errors: %0d",
                 errors, timeouts, UUT.u_sva.fail_cnt);
        if (errors == 0 && timeouts == 0 && UUT.u_sva.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
src/exec_pkg.sv
src/apb_pkg.sv
src/exec_alu.sv
src/exec_lane.sv
src/exec_dispatch.sv
src/exec_collect.sv
src/exec_cluster.sv
bench/exec_cluster_sva.sv
bench/tb_exec_cluster.sv

// ==== Makefile ====
TOP = tb_exec_cluster

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f all.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee run.log
	grep -q "Test completed successfully" run.log

clean:
	rm -rf obj_dir run.log
